//--- hdl/mipsPkg.sv
package mipsPkg;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opRegimm  = 6'h01,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBgtz    = 6'h07,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23
    } functE;

    typedef enum logic [2:0] {aluAdd, aluSub, aluOr, aluSll, aluLui} aluOpE;

    typedef enum logic [1:0] {extZero, extSign, extUpper} extSelE;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelE;

    typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstE;

    typedef enum logic [2:0] {
        npcSeq, npcBeq, npcBgtz, npcBgezal, npcJump, npcJumpReg
    } npcSelE;

    localparam logic [31:0] resetPc = 32'h0000_3000;
    localparam int dmWords = 1024;
    localparam int dmAddrBits = $clog2(dmWords);
    localparam logic [4:0] linkReg = 5'd31;

endpackage

//--- hdl/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;

    mipsPkg::aluOpE  aluOp;
    logic            aluSrc;
    mipsPkg::extSelE extSel;
    mipsPkg::regDstE regDst;
    mipsPkg::wbSelE  wbSel;
    logic            regWrite;
    logic            memWrite;
    mipsPkg::npcSelE npcSel;

    modport controller (
        output aluOp, aluSrc, extSel, regDst, wbSel, regWrite, memWrite, npcSel
    );

    modport execUnit (input aluOp, aluSrc, extSel);
    modport grf (input regDst, wbSel, regWrite);
    modport dm (input memWrite);
    modport ifu (input npcSel);

endinterface

//--- hdl/ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic        clk,
    input  logic        rst,
    ctrlIf.ifu          ctrl,
    input  logic        zero,
    input  logic        gtZero,
    input  logic        ltZero,
    input  logic [25:0] instrIndex,
    input  logic [31:0] extImm,
    input  logic [31:0] rsValue,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);

    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] npc;

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};
    // Region bits come from the delay-slot-free pc + 4
    assign jumpTarget = {pcPlus4[31:28], instrIndex, 2'b00};

    always_comb begin
        case (ctrl.npcSel)
            mipsPkg::npcBeq:     npc = zero ? branchTarget : pcPlus4;
            mipsPkg::npcBgtz:    npc = gtZero ? branchTarget : pcPlus4;
            mipsPkg::npcBgezal:  npc = ltZero ? pcPlus4 : branchTarget;
            mipsPkg::npcJump:    npc = jumpTarget;
            mipsPkg::npcJumpReg: npc = rsValue;
            default:             npc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= mipsPkg::resetPc;
        end else begin
            pc <= npc;
        end
    end

    // jr target comes straight from the register file
    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- hdl/controller.sv
`timescale 1ns/1ps

module controller (
    input  logic [31:0] instr,
    ctrlIf.controller   ctrl
);

    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;
    logic            isBgezal;

    assign opcode = mipsPkg::opcodeE'(instr[31:26]);
    assign funct = mipsPkg::functE'(instr[5:0]);
    // Only the bgezal variant of regimm is supported
    assign isBgezal = (instr[20:16] == 5'b10001);

    always_comb begin
        ctrl.aluOp = mipsPkg::aluAdd;
        ctrl.aluSrc = 1'b0;
        ctrl.extSel = mipsPkg::extZero;
        ctrl.regDst = mipsPkg::dstRt;
        ctrl.wbSel = mipsPkg::wbAlu;
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.npcSel = mipsPkg::npcSeq;

        case (opcode)
            mipsPkg::opSpecial: begin
                case (funct)
                    mipsPkg::fnAddu: begin
                        ctrl.regDst = mipsPkg::dstRd;
                        ctrl.regWrite = 1'b1;
                    end
                    mipsPkg::fnSubu: begin
                        ctrl.aluOp = mipsPkg::aluSub;
                        ctrl.regDst = mipsPkg::dstRd;
                        ctrl.regWrite = 1'b1;
                    end
                    mipsPkg::fnSll: begin
                        ctrl.aluOp = mipsPkg::aluSll;
                        ctrl.regDst = mipsPkg::dstRd;
                        ctrl.regWrite = 1'b1;
                    end
                    mipsPkg::fnJr: ctrl.npcSel = mipsPkg::npcJumpReg;
                    default: ;
                endcase
            end
            mipsPkg::opRegimm: begin
                if (isBgezal) begin
                    ctrl.extSel = mipsPkg::extSign;
                    ctrl.regDst = mipsPkg::dstLink;
                    ctrl.wbSel = mipsPkg::wbPcPlus4;
                    ctrl.regWrite = 1'b1;
                    ctrl.npcSel = mipsPkg::npcBgezal;
                end
            end
            mipsPkg::opOri: begin
                ctrl.aluOp = mipsPkg::aluOr;
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opLui: begin
                ctrl.aluOp = mipsPkg::aluLui;
                ctrl.aluSrc = 1'b1;
                ctrl.extSel = mipsPkg::extUpper;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opLw: begin
                ctrl.aluSrc = 1'b1;
                ctrl.extSel = mipsPkg::extSign;
                ctrl.wbSel = mipsPkg::wbMem;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrc = 1'b1;
                ctrl.extSel = mipsPkg::extSign;
                ctrl.memWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.extSel = mipsPkg::extSign;
                ctrl.npcSel = mipsPkg::npcBeq;
            end
            mipsPkg::opBgtz: begin
                ctrl.extSel = mipsPkg::extSign;
                ctrl.npcSel = mipsPkg::npcBgtz;
            end
            mipsPkg::opJ: ctrl.npcSel = mipsPkg::npcJump;
            mipsPkg::opJal: begin
                ctrl.regDst = mipsPkg::dstLink;
                ctrl.wbSel = mipsPkg::wbPcPlus4;
                ctrl.regWrite = 1'b1;
                ctrl.npcSel = mipsPkg::npcJump;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/grf.sv
`timescale 1ns/1ps

module grf (
    input  logic        clk,
    input  logic        rst,
    ctrlIf.grf          ctrl,
    input  logic [31:0] instr,
    input  logic [31:0] aluResult,
    input  logic [31:0] readData,
    input  logic [31:0] pcPlus4,
    input  logic        ltZero,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic        regWe,
    output logic [4:0]  regWaddr,
    output logic [31:0] regWdata
);

    logic [31:0] regs [32];
    logic [4:0]  linkAddr;

    assign rd1 = regs[instr[25:21]];
    assign rd2 = regs[instr[20:16]];

    // Untaken bgezal still writes, but to register 0
    assign linkAddr = (instr[31:26] == mipsPkg::opRegimm && ltZero) ? 5'd0
                                                                     : mipsPkg::linkReg;

    always_comb begin
        case (ctrl.regDst)
            mipsPkg::dstRd:   regWaddr = instr[15:11];
            mipsPkg::dstLink: regWaddr = linkAddr;
            default:          regWaddr = instr[20:16];
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            mipsPkg::wbMem:     regWdata = readData;
            mipsPkg::wbPcPlus4: regWdata = pcPlus4;
            default:            regWdata = aluResult;
        endcase
    end

    assign regWe = ctrl.regWrite & ~rst;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe && regWaddr != 5'd0) begin
            regs[regWaddr] <= regWdata;
        end
    end

endmodule

//--- hdl/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    ctrlIf.execUnit     ctrl,
    input  logic [31:0] instr,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    output logic [31:0] aluResult,
    output logic [31:0] extImm,
    output logic        zero,
    output logic        gtZero,
    output logic        ltZero
);

    logic [15:0] imm16;
    logic [4:0]  shamt;
    logic [31:0] srcB;

    assign imm16 = instr[15:0];
    assign shamt = instr[10:6];

    always_comb begin
        case (ctrl.extSel)
            mipsPkg::extSign:  extImm = {{16{imm16[15]}}, imm16};
            mipsPkg::extUpper: extImm = {imm16, 16'h0000};
            default:           extImm = {16'h0000, imm16};
        endcase
    end

    assign srcB = ctrl.aluSrc ? extImm : rd2;

    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::aluSub: aluResult = rd1 - srcB;
            mipsPkg::aluOr:  aluResult = rd1 | srcB;
            // sll shifts rt, which is srcB for R-type
            mipsPkg::aluSll: aluResult = srcB << shamt;
            mipsPkg::aluLui: aluResult = srcB;
            default:         aluResult = rd1 + srcB;
        endcase
    end

    // Branch flags
    assign zero = (rd1 == rd2);
    assign ltZero = rd1[31];
    assign gtZero = ~rd1[31] && (rd1 != 32'd0);

endmodule

//--- hdl/dm.sv
`timescale 1ns/1ps

module dm (
    input  logic        clk,
    input  logic        rst,
    ctrlIf.dm           ctrl,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] readData,
    output logic        memWe
);

    logic [31:0] mem [mipsPkg::dmWords];
    logic [mipsPkg::dmAddrBits-1:0] wordIdx;

    assign wordIdx = addr[mipsPkg::dmAddrBits+1:2];
    assign readData = mem[wordIdx];
    assign memWe = ctrl.memWrite & ~rst;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mipsPkg::dmWords; i++) begin
                mem[i] <= '0;
            end
        end else if (memWe) begin
            mem[wordIdx] <= wdata;
        end
    end

    // Address comes from the ALU, base plus offset
    wrAddrOk: assert property (@(posedge clk) disable iff (rst)
        memWe |-> (addr[1:0] == 2'b00 && addr < 32'(mipsPkg::dmWords * 4)));

endmodule

//--- hdl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output logic        regWe,
    output logic [4:0]  regWaddr,
    output logic [31:0] regWdata,
    output logic        memWe,
    output logic [31:0] memAddr,
    output logic [31:0] memWdata
);

    ctrlIf ctrl ();

    logic [31:0] pcPlus4;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] aluResult;
    logic [31:0] extImm;
    logic [31:0] readData;
    logic        zero;
    logic        gtZero;
    logic        ltZero;

    // Store path
    assign memAddr = aluResult;
    assign memWdata = rd2;

    ifu ifuInst (
        .clk(clk), .rst(rst), .ctrl(ctrl),
        .zero(zero), .gtZero(gtZero), .ltZero(ltZero),
        .instrIndex(instr[25:0]), .extImm(extImm), .rsValue(rd1),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    controller controllerInst (.instr(instr), .ctrl(ctrl));

    grf grfInst (
        .clk(clk), .rst(rst), .ctrl(ctrl), .instr(instr),
        .aluResult(aluResult), .readData(readData), .pcPlus4(pcPlus4),
        .ltZero(ltZero), .rd1(rd1), .rd2(rd2),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata)
    );

    execUnit execUnitInst (
        .ctrl(ctrl), .instr(instr), .rd1(rd1), .rd2(rd2),
        .aluResult(aluResult), .extImm(extImm),
        .zero(zero), .gtZero(gtZero), .ltZero(ltZero)
    );

    dm dmInst (
        .clk(clk), .rst(rst), .ctrl(ctrl),
        .addr(memAddr), .wdata(memWdata),
        .readData(readData), .memWe(memWe)
    );

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

//--- dv/mipsChecker.sv
`timescale 1ns/1ps

module mipsChecker (
    input  logic        clk,
    input  logic        active,
    input  logic [31:0] pc,
    input  logic        regWe,
    input  logic [4:0]  regWaddr,
    input  logic [31:0] regWdata,
    input  logic        memWe,
    input  logic [31:0] memAddr,
    input  logic [31:0] memWdata,
    input  logic [31:0] expPc,
    input  logic        expRegWe,
    input  logic [4:0]  expRegWaddr,
    input  logic [31:0] expRegWdata,
    input  logic        expMemWe,
    input  logic [31:0] expMemAddr,
    input  logic [31:0] expMemWdata,
    output int          errors,
    output int          checks
);

    int errCount = 0;
    int checkCount = 0;

    assign errors = errCount;
    assign checks = checkCount;

    task automatic compareVal(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("error %s exp %h got %h", name, exp, got);
        end
    endtask

    // Ports still hold this cycle's values, register updates land later
    always @(posedge clk) begin
        if (active) begin
            compareVal("pc", expPc, pc);
            compareVal("regWe", {31'd0, expRegWe}, {31'd0, regWe});
            compareVal("memWe", {31'd0, expMemWe}, {31'd0, memWe});
            if (expRegWe) begin
                compareVal("regWaddr", {27'd0, expRegWaddr}, {27'd0, regWaddr});
                compareVal("regWdata", expRegWdata, regWdata);
            end
            if (expMemWe) begin
                compareVal("memAddr", expMemAddr, memAddr);
                compareVal("memWdata", expMemWdata, memWdata);
            end
        end
    end

endmodule

//--- dv/mipsTb.sv
`timescale 1ns/1ps

module mipsTb;

    localparam int numInstr = 400;
    localparam int cycleLimit = numInstr + 5 + 20;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        regWe;
    logic [4:0]  regWaddr;
    logic [31:0] regWdata;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;

    logic        active;
    logic [31:0] expPc;
    logic        expRegWe;
    logic [4:0]  expRegWaddr;
    logic [31:0] expRegWdata;
    logic        expMemWe;
    logic [31:0] expMemAddr;
    logic [31:0] expMemWdata;
    int          errors;
    int          checks;
    int          cycles;

    // Reference ISA state
    logic [31:0] regs [32];
    logic [31:0] mem [mipsPkg::dmWords];
    logic [31:0] modelPc;
    logic [31:0] nextPc;
    logic [31:0] rngState;

    tbClock clkGen (.clk(clk));

    mipsCore mipsCore_inst (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
    );

    mipsChecker checkerInst (
        .clk(clk), .active(active), .pc(pc),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
        .expPc(expPc), .expRegWe(expRegWe), .expRegWaddr(expRegWaddr),
        .expRegWdata(expRegWdata), .expMemWe(expMemWe), .expMemAddr(expMemAddr),
        .expMemWdata(expMemWdata), .errors(errors), .checks(checks)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic bit isKnownOp(input logic [5:0] op);
        case (op)
            6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h07, 6'h0d, 6'h0f, 6'h23, 6'h2b: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Register 0 always qualifies, so the scan ends
    function automatic logic [4:0] alignedReg(input logic [4:0] start);
        logic [4:0] r;
        r = start;
        for (int i = 0; i < 32; i++) begin
            if (regs[r][1:0] == 2'b00) begin
                return r;
            end
            r = r + 5'd1;
        end
        return 5'd0;
    endfunction

    function automatic logic [31:0] drawInstr();
        logic [31:0] r;
        logic [31:0] f;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] off;
        logic [5:0]  op;
        r = nextRand();
        f = nextRand();
        rs = f[25:21];
        rt = r[20] ? rs : f[20:16];
        rd = f[15:11];
        // Small offsets make lw hit earlier sw addresses
        off = r[4] ? {11'd0, r[10:8], 2'b00} : {4'd0, r[17:8], 2'b00};
        case (r[3:0])
            4'd0: return {6'h00, rs, f[20:16], rd, 5'd0, 6'h21};
            4'd1: return {6'h00, rs, f[20:16], rd, 5'd0, 6'h23};
            4'd2: return {6'h00, 5'd0, f[20:16], rd, f[10:6], 6'h00};
            4'd4: return {6'h0f, 5'd0, f[20:16], f[15:0]};
            4'd5: return {6'h23, 5'd0, f[20:16], off};
            4'd6: return {6'h2b, 5'd0, f[20:16], off};
            4'd7: return {6'h04, rs, rt, f[15:0]};
            4'd8: return {6'h07, rs, 5'd0, f[15:0]};
            4'd9: return {6'h01, rs, 5'b10001, f[15:0]};
            4'd10: return {6'h02, f[25:0]};
            4'd11: return {6'h03, f[25:0]};
            4'd12: return {6'h00, alignedReg(rs), 15'd0, 6'h08};
            4'd13: begin
                op = isKnownOp(f[31:26]) ? 6'h3f : f[31:26];
                return {op, f[25:0]};
            end
            default: return {6'h0d, rs, f[20:16], f[15:0]};
        endcase
    endfunction

    task automatic predict(input logic [31:0] w);
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] pc4;
        logic [31:0] simm;
        logic [31:0] brTarget;
        rsV = regs[w[25:21]];
        rtV = regs[w[20:16]];
        pc4 = modelPc + 32'd4;
        simm = {{16{w[15]}}, w[15:0]};
        brTarget = pc4 + (simm << 2);
        expPc = modelPc;
        expRegWe = 1'b0;
        expRegWaddr = 5'd0;
        expRegWdata = 32'd0;
        expMemWe = 1'b0;
        expMemAddr = 32'd0;
        expMemWdata = 32'd0;
        nextPc = pc4;
        case (w[31:26])
            6'h00: begin
                expRegWe = (w[5:0] == 6'h21 || w[5:0] == 6'h23 || w[5:0] == 6'h00);
                expRegWaddr = w[15:11];
                if (w[5:0] == 6'h21) expRegWdata = rsV + rtV;
                if (w[5:0] == 6'h23) expRegWdata = rsV - rtV;
                if (w[5:0] == 6'h00) expRegWdata = rtV << w[10:6];
                if (w[5:0] == 6'h08) nextPc = rsV;
            end
            6'h01: begin
                if (w[20:16] == 5'b10001) begin
                    expRegWe = 1'b1;
                    expRegWaddr = $signed(rsV) >= 0 ? mipsPkg::linkReg : 5'd0;
                    expRegWdata = pc4;
                    nextPc = $signed(rsV) >= 0 ? brTarget : pc4;
                end
            end
            6'h0d: begin
                expRegWe = 1'b1;
                expRegWaddr = w[20:16];
                expRegWdata = rsV | {16'h0000, w[15:0]};
            end
            6'h0f: begin
                expRegWe = 1'b1;
                expRegWaddr = w[20:16];
                expRegWdata = {w[15:0], 16'h0000};
            end
            6'h23: begin
                expRegWe = 1'b1;
                expRegWaddr = w[20:16];
                expRegWdata = mem[((rsV + simm) >> 2) % mipsPkg::dmWords];
            end
            6'h2b: begin
                expMemWe = 1'b1;
                expMemAddr = rsV + simm;
                expMemWdata = rtV;
            end
            6'h04: nextPc = (rsV == rtV) ? brTarget : pc4;
            6'h07: nextPc = ($signed(rsV) > 0) ? brTarget : pc4;
            6'h02: nextPc = {pc4[31:28], w[25:0], 2'b00};
            6'h03: begin
                expRegWe = 1'b1;
                expRegWaddr = mipsPkg::linkReg;
                expRegWdata = pc4;
                nextPc = {pc4[31:28], w[25:0], 2'b00};
            end
            default: ;
        endcase
    endtask

    task automatic commitStep();
        if (expRegWe && expRegWaddr != 5'd0) begin
            regs[expRegWaddr] = expRegWdata;
        end
        if (expMemWe) begin
            mem[(expMemAddr >> 2) % mipsPkg::dmWords] = expMemWdata;
        end
        modelPc = nextPc;
    endtask

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, instruction stream did not finish", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        instr = 32'd0;
        active = 1'b0;
        rngState = 32'he854_ddde;
        modelPc = mipsPkg::resetPc;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < mipsPkg::dmWords; i++) begin
            mem[i] = 32'd0;
        end
        @(posedge clk);
        @(negedge clk);
        // Reset holds the write enables low whatever instr says
        active = 1'b1;
        expPc = mipsPkg::resetPc;
        expRegWe = 1'b0;
        expMemWe = 1'b0;
        repeat (4) begin
            instr = drawInstr();
            @(negedge clk);
        end
        rst = 1'b0;
        for (int n = 0; n < numInstr; n++) begin
            if (n > 0) begin
                commitStep();
            end
            instr = drawInstr();
            predict(instr);
            @(negedge clk);
        end
        active = 1'b0;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- mipsCore.f
hdl/mipsPkg.sv
hdl/ctrlIf.sv
hdl/ifu.sv
hdl/controller.sv
hdl/grf.sv
hdl/execUnit.sv
hdl/dm.sv
hdl/mipsCore.sv
dv/tbClock.sv
dv/mipsChecker.sv
dv/mipsTb.sv
